//--- logic/tft_params.svh
`ifndef TFT_PARAMS_SVH
`define TFT_PARAMS_SVH

// command word fields
`define TFT_DELAY_BIT      31
`define TFT_READ_PREFIX    8'h40

// shift counts inside one frame
`define TFT_CAP_FIRST      5'd8
`define TFT_SHIFT_LAST     5'd16

// host fifo and arbiter slots
`define TFT_QUEUE_DEPTH    4
`define TFT_PORT_CREDITS   1

// power-up list
`define TFT_INIT_LEN       4
`define TFT_INIT_0         32'h0000_8001
`define TFT_INIT_1         32'h0000_0080
// frame, not a delay: bit 31 is clear
`define TFT_INIT_2         32'h0000_0003
// 16-cycle delay
`define TFT_INIT_3         32'h8000_0010

`endif

//--- logic/tft_pkg.sv
package tft_pkg;

    // who issued a word
    typedef enum logic {
        SRC_HOST = 1'b0,
        SRC_INIT = 1'b1
    } tft_src_e;

    // one 32-bit command word, read either as a delay or as an SPI frame
    typedef union packed {
        struct packed {
            logic        flag;
            logic [30:0] count;
        } delay;
        struct packed {
            logic        flag;
            logic [14:0] unused;
            logic [7:0]  prefix;
            logic [7:0]  data;
        } frame;
    } tft_cmd_u;

    // word toward the engine, 34 bits
    typedef struct packed {
        logic     valid;
        tft_src_e src;
        tft_cmd_u cmd;
    } tft_req_t;

    // read byte back from the engine, 10 bits
    typedef struct packed {
        logic       valid;
        tft_src_e   src;
        logic [7:0] data;
    } tft_rsp_t;

endpackage

//--- logic/tft_spi_engine.sv
`timescale 1ns/1ps
`include "tft_params.svh"

module tft_spi_engine (
    input  logic              clk,
    input  logic              nrst,
    input  tft_pkg::tft_req_t eng_req,
    output logic              eng_credit,
    output tft_pkg::tft_rsp_t eng_rsp,
    input  logic              miso,
    output logic              chip_select,
    output logic              bit_data,
    output logic              sclk
);

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_SETUP = 2'd1,
        ST_SHIFT = 2'd2,
        ST_DELAY = 2'd3
    } state_t;

    state_t            state;
    tft_pkg::tft_cmd_u cmd_reg;
    tft_pkg::tft_src_e src_reg;
    logic [15:0]       shift_reg;
    logic [4:0]        bit_cnt;
    logic [30:0]       delay_cnt;
    logic              read_flag;
    logic [7:0]        capture;
    logic [7:0]        next_capture;
    logic              cap_en;
    logic              frame_done;
    logic              delay_done;
    logic              zero_delay;

    // a delay of zero finishes straight out of setup
    assign zero_delay = (state == ST_SETUP) && cmd_reg.delay.flag &&
                        (cmd_reg.delay.count == 31'd0);

    assign frame_done = (state == ST_SHIFT) && (bit_cnt == `TFT_SHIFT_LAST);
    assign delay_done = ((state == ST_DELAY) && (delay_cnt == 31'd1)) || zero_delay;

    // miso sampled on shift counts 8..16, last eight samples kept
    assign cap_en       = (state == ST_SHIFT) && read_flag && (bit_cnt >= `TFT_CAP_FIRST);
    assign next_capture = {capture[6:0], miso};

    assign eng_credit = frame_done || delay_done;

    assign eng_rsp.valid = frame_done && read_flag;
    assign eng_rsp.src   = src_reg;
    assign eng_rsp.data  = next_capture;

    // pins idle high, sclk follows the inverted clock while shifting
    assign chip_select = (state != ST_SHIFT);
    assign bit_data    = (state == ST_SHIFT) ? shift_reg[15] : 1'b1;
    assign sclk        = (state == ST_SHIFT) ? ~clk : 1'b1;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state     <= ST_IDLE;
            bit_cnt   <= '0;
            delay_cnt <= '0;
            read_flag <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (eng_req.valid) begin
                        state <= ST_SETUP;
                    end
                end
                ST_SETUP: begin
                    bit_cnt <= '0;
                    if (cmd_reg.delay.flag) begin
                        read_flag <= 1'b0;
                        delay_cnt <= cmd_reg.delay.count;
                        if (zero_delay) begin
                            state <= ST_IDLE;
                        end else begin
                            state <= ST_DELAY;
                        end
                    end else begin
                        read_flag <= (cmd_reg.frame.prefix == `TFT_READ_PREFIX);
                        state     <= ST_SHIFT;
                    end
                end
                ST_SHIFT: begin
                    bit_cnt <= bit_cnt + 5'd1;
                    if (frame_done) begin
                        state <= ST_IDLE;
                    end
                end
                ST_DELAY: begin
                    delay_cnt <= delay_cnt - 31'd1;
                    if (delay_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // word, frame and read byte
    always_ff @(posedge clk) begin
        if ((state == ST_IDLE) && eng_req.valid) begin
            cmd_reg <= eng_req.cmd;
            src_reg <= eng_req.src;
        end

        if (state == ST_SETUP) begin
            shift_reg <= {cmd_reg.frame.prefix, cmd_reg.frame.data};
        end else if (state == ST_SHIFT) begin
            // MSB first
            shift_reg <= {shift_reg[14:0], 1'b0};
        end

        if (cap_en) begin
            capture <= next_capture;
        end
    end

endmodule

//--- logic/tft_cmd_queue.sv
`timescale 1ns/1ps
`include "tft_params.svh"

module tft_cmd_queue (
    input  logic              clk,
    input  logic              nrst,
    input  tft_pkg::tft_req_t host_req,
    output logic              host_credit,
    output tft_pkg::tft_req_t arb_req,
    input  logic              arb_credit,
    input  tft_pkg::tft_rsp_t arb_rsp,
    output tft_pkg::tft_rsp_t host_rsp
);

    localparam int DEPTH = `TFT_QUEUE_DEPTH;
    localparam int AW    = $clog2(DEPTH);
    localparam int CW    = $clog2(`TFT_PORT_CREDITS + 1);

    tft_pkg::tft_cmd_u fifo_mem [DEPTH];
    logic [AW-1:0]     wr_ptr;
    logic [AW-1:0]     rd_ptr;
    logic [AW:0]       fill;
    logic [CW-1:0]     arb_cnt;
    logic              push;
    logic              pop;

    assign push = host_req.valid;
    // head leaves only while a slot at the arbiter is free
    assign pop  = (fill != '0) && (arb_cnt != '0);

    assign arb_req.valid = pop;
    assign arb_req.src   = tft_pkg::SRC_HOST;
    assign arb_req.cmd   = fifo_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= host_req.cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            fill        <= '0;
            arb_cnt     <= CW'(`TFT_PORT_CREDITS);
            host_credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end

            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase

            case ({pop, arb_credit})
                2'b10:   arb_cnt <= arb_cnt - 1'b1;
                2'b01:   arb_cnt <= arb_cnt + 1'b1;
                default: arb_cnt <= arb_cnt;
            endcase

            // the freed entry goes back to the host a cycle later
            host_credit <= pop;
        end
    end

    // read responses, one cycle behind the arbiter
    always_ff @(posedge clk) begin
        host_rsp.src  <= arb_rsp.src;
        host_rsp.data <= arb_rsp.data;
        if (!nrst) begin
            host_rsp.valid <= 1'b0;
        end else begin
            host_rsp.valid <= arb_rsp.valid;
        end
    end

endmodule

//--- logic/tft_init_seq.sv
`timescale 1ns/1ps
`include "tft_params.svh"

module tft_init_seq (
    input  logic              clk,
    input  logic              nrst,
    output tft_pkg::tft_req_t arb_req,
    input  logic              arb_credit,
    output logic              init_done
);

    localparam int IW = $clog2(`TFT_INIT_LEN + 1);
    localparam int CW = $clog2(`TFT_PORT_CREDITS + 1);

    logic [IW-1:0]     word_idx;
    logic [CW-1:0]     credit_cnt;
    logic              started;
    logic              send;
    tft_pkg::tft_cmd_u cur_word;

    // power-up list
    always_comb begin
        case (word_idx)
            IW'(0):  cur_word = `TFT_INIT_0;
            IW'(1):  cur_word = `TFT_INIT_1;
            IW'(2):  cur_word = `TFT_INIT_2;
            IW'(3):  cur_word = `TFT_INIT_3;
            default: cur_word = '0;
        endcase
    end

    assign send = started && !init_done && (credit_cnt != '0);

    assign arb_req.valid = send;
    assign arb_req.src   = tft_pkg::SRC_INIT;
    assign arb_req.cmd   = cur_word;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            started    <= 1'b0;
            word_idx   <= '0;
            credit_cnt <= CW'(`TFT_PORT_CREDITS);
            init_done  <= 1'b0;
        end else begin
            // first cycle out of reset stays quiet
            started <= 1'b1;

            if (send) begin
                word_idx <= word_idx + 1'b1;
                if (word_idx == IW'(`TFT_INIT_LEN - 1)) begin
                    init_done <= 1'b1;
                end
            end

            case ({send, arb_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

endmodule

//--- logic/tft_spi_arbiter.sv
`timescale 1ns/1ps

module tft_spi_arbiter (
    input  logic              clk,
    input  logic              nrst,
    input  tft_pkg::tft_req_t host_req,
    output logic              host_credit,
    input  tft_pkg::tft_req_t init_req,
    output logic              init_credit,
    output tft_pkg::tft_req_t eng_req,
    input  logic              eng_credit,
    input  tft_pkg::tft_rsp_t eng_rsp,
    output tft_pkg::tft_rsp_t host_rsp
);

    tft_pkg::tft_req_t host_slot;
    tft_pkg::tft_req_t init_slot;
    tft_pkg::tft_req_t chosen;
    tft_pkg::tft_src_e last_win;
    logic              eng_cnt;
    logic              pick_init;
    logic              issue;

    // round robin, init wins a tie right after reset
    assign pick_init = init_slot.valid &&
                       (!host_slot.valid || (last_win == tft_pkg::SRC_HOST));
    assign chosen    = pick_init ? init_slot : host_slot;
    assign issue     = eng_cnt && (host_slot.valid || init_slot.valid);

    assign eng_req.valid = issue;
    assign eng_req.src   = chosen.src;
    assign eng_req.cmd   = chosen.cmd;

    // slot frees as its word goes to the engine
    assign init_credit = issue && pick_init;
    assign host_credit = issue && !pick_init;

    // only host reads go back, init reads are dropped
    assign host_rsp.valid = eng_rsp.valid && (eng_rsp.src == tft_pkg::SRC_HOST);
    assign host_rsp.src   = eng_rsp.src;
    assign host_rsp.data  = eng_rsp.data;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            host_slot.valid <= 1'b0;
            init_slot.valid <= 1'b0;
            last_win        <= tft_pkg::SRC_HOST;
            eng_cnt         <= 1'b1;
        end else begin
            if (host_req.valid) begin
                host_slot.valid <= 1'b1;
            end else if (host_credit) begin
                host_slot.valid <= 1'b0;
            end

            if (init_req.valid) begin
                init_slot.valid <= 1'b1;
            end else if (init_credit) begin
                init_slot.valid <= 1'b0;
            end

            if (issue) begin
                last_win <= pick_init ? tft_pkg::SRC_INIT : tft_pkg::SRC_HOST;
            end

            // engine credit comes back when the engine is idle again
            if (issue && !eng_credit) begin
                eng_cnt <= 1'b0;
            end else if (eng_credit && !issue) begin
                eng_cnt <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (host_req.valid) begin
            host_slot.src <= host_req.src;
            host_slot.cmd <= host_req.cmd;
        end
        if (init_req.valid) begin
            init_slot.src <= init_req.src;
            init_slot.cmd <= init_req.cmd;
        end
    end

endmodule

//--- logic/tft_subsystem.sv
`timescale 1ns/1ps

module tft_subsystem (
    input  logic              clk,
    input  logic              nrst,
    input  tft_pkg::tft_req_t host_req,
    output logic              host_credit,
    output tft_pkg::tft_rsp_t host_rsp,
    output logic              init_done,
    input  logic              miso,
    output logic              chip_select,
    output logic              bit_data,
    output logic              sclk
);

    // queue and sequencer into the arbiter
    tft_pkg::tft_req_t q_arb_req;
    logic              q_arb_credit;
    tft_pkg::tft_rsp_t q_arb_rsp;
    tft_pkg::tft_req_t init_arb_req;
    logic              init_arb_credit;

    // arbiter to engine
    tft_pkg::tft_req_t eng_req;
    logic              eng_credit;
    tft_pkg::tft_rsp_t eng_rsp;

    tft_cmd_queue u_queue (
        .clk         (clk),
        .nrst        (nrst),
        .host_req    (host_req),
        .host_credit (host_credit),
        .arb_req     (q_arb_req),
        .arb_credit  (q_arb_credit),
        .arb_rsp     (q_arb_rsp),
        .host_rsp    (host_rsp)
    );

    tft_init_seq u_init (
        .clk        (clk),
        .nrst       (nrst),
        .arb_req    (init_arb_req),
        .arb_credit (init_arb_credit),
        .init_done  (init_done)
    );

    tft_spi_arbiter u_arb (
        .clk         (clk),
        .nrst        (nrst),
        .host_req    (q_arb_req),
        .host_credit (q_arb_credit),
        .init_req    (init_arb_req),
        .init_credit (init_arb_credit),
        .eng_req     (eng_req),
        .eng_credit  (eng_credit),
        .eng_rsp     (eng_rsp),
        .host_rsp    (q_arb_rsp)
    );

    tft_spi_engine u_eng (
        .clk         (clk),
        .nrst        (nrst),
        .eng_req     (eng_req),
        .eng_credit  (eng_credit),
        .eng_rsp     (eng_rsp),
        .miso        (miso),
        .chip_select (chip_select),
        .bit_data    (bit_data),
        .sclk        (sclk)
    );

endmodule

//--- sim/tft_tb.sv
`timescale 1ns/1ps
`include "tft_params.svh"

module tft_tb;

    localparam int DEPTH        = `TFT_QUEUE_DEPTH;
    localparam int INIT_DELAY   = 16;
    localparam int NUM_WRITES   = 20;
    localparam int NUM_READS    = 6;
    localparam int DELAY_N      = 40;
    localparam int LONG_DELAY   = 150;
    localparam int BURSTS       = 2;
    localparam int BURST_FRAMES = 8;
    localparam int ARB_WORDS    = 4;

    // expected outcome of one frame word
    typedef struct packed {
        logic [15:0] frame;
        logic        is_read;
        logic [7:0]  rd_byte;
        logic [7:0]  next_data;
    } ref_t;

    logic              clk = 1'b0;
    logic              nrst;
    tft_pkg::tft_req_t host_req;
    logic              host_credit;
    tft_pkg::tft_rsp_t host_rsp;
    logic              init_done;
    logic              miso;
    logic              chip_select;
    logic              bit_data;
    logic              sclk;

    int                seed;
    int                errors = 0;
    int                test_errors;
    int                tests_ok = 0;
    int                tests_bad = 0;
    int                credits;
    int                credit_pulses = 0;
    int                words_sent = 0;
    logic              ran_out;
    int                rsp_count = 0;
    int                host_between = 0;
    int                next_gap = 0;
    logic [31:0]       pend [$];
    logic [31:0]       host_exp_word [$];
    int                host_exp_gap [$];
    logic [31:0]       init_exp [$];
    tft_pkg::tft_rsp_t rsp_exp [$];
    logic [15:0]       got_frames [$];
    int                got_gaps [$];
    logic [7:0]        ref_data = 8'h00;

    // RA8875 side
    logic              in_frame = 1'b0;
    int                rise_cnt;
    int                cur_gap;
    logic [15:0]       mosi_bits;
    logic [7:0]        model_data = 8'h00;
    logic [7:0]        model_reg = 8'h00;
    time               last_rise = 0;

    tft_subsystem uut (
        .clk         (clk),
        .nrst        (nrst),
        .host_req    (host_req),
        .host_credit (host_credit),
        .host_rsp    (host_rsp),
        .init_done   (init_done),
        .miso        (miso),
        .chip_select (chip_select),
        .bit_data    (bit_data),
        .sclk        (sclk)
    );

    always #50 clk = ~clk;

    function automatic ref_t ref_frame(input logic [31:0] word, input logic [7:0] data_reg);
        ref_t r;
        r.frame     = word[15:0];
        r.is_read   = (word[15:8] == 8'h40);
        r.rd_byte   = data_reg;
        // a write frame loads the display data register
        r.next_data = (word[15:8] == 8'h00) ? word[7:0] : data_reg;
        return r;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // (18 cycles per frame + delays + 20) per test, doubled, plus resets
    function automatic int watchdog_cycles();
        int total;
        total = (18 * 4 + 16 + 20) + (18 * NUM_WRITES + 20) + (18 * 2 * NUM_READS + 20);
        total = total + (18 * 2 + DELAY_N + 20);
        total = total + (BURSTS * (18 * BURST_FRAMES + LONG_DELAY) + 20);
        total = total + (18 * (3 + ARB_WORDS) + 16 + 20);
        return 2 * total + 2 * 5;
    endfunction

    task automatic check_frame(input logic [15:0] got, input logic [15:0] exp,
                               input tft_pkg::tft_src_e src);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH bit_data %s frame got 0x%04h expected 0x%04h",
                     (src == tft_pkg::SRC_INIT) ? "init" : "host", got, exp);
        end
    endtask

    task automatic check_rsp(input tft_pkg::tft_rsp_t got, input tft_pkg::tft_rsp_t exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH host_rsp got 0x%03h expected 0x%03h", got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_gap(input int got, input int min_cycles);
        if (got < min_cycles) begin
            errors++;
            $display("chip select was high for only %0d cycles before a frame, %0d were due",
                     got, min_cycles);
        end
    endtask

    // slave model, frames sampled on sclk rising
    always @(negedge chip_select) begin
        in_frame  = 1'b1;
        rise_cnt  = 0;
        mosi_bits = '0;
        cur_gap   = int'(($time - last_rise) / 100);
    end

    always @(posedge sclk) begin
        if (in_frame && chip_select === 1'b0) begin
            if (rise_cnt < 16) begin
                mosi_bits = {mosi_bits[14:0], bit_data};
            end
            // the engine keeps the miso bits it samples after shift counts 9..16
            if (rise_cnt >= 9 && rise_cnt <= 16) begin
                miso = model_data[16 - rise_cnt];
            end
            rise_cnt = rise_cnt + 1;
        end
    end

    always @(posedge chip_select) begin
        if (in_frame) begin
            in_frame  = 1'b0;
            last_rise = $time;
            if (rise_cnt < 16) begin
                errors++;
                $display("a frame ended after only %0d sclk edges", rise_cnt);
            end
            if (mosi_bits[15:8] == 8'h00) begin
                model_data = mosi_bits[7:0];
            end else if (mosi_bits[15:8] == 8'h80) begin
                model_reg = mosi_bits[7:0];
            end
            got_frames.push_back(mosi_bits);
            got_gaps.push_back(cur_gap);
        end
    end

    // host side, one word per cycle under credits
    always @(negedge clk) begin : host_driver
        tft_pkg::tft_cmd_u w;
        host_req = '0;
        if (nrst !== 1'b1) begin
            credits = DEPTH;
        end else begin
            if (host_credit === 1'b1) begin
                credits++;
                credit_pulses++;
            end
            if (pend.size() > 0 && credits > 0) begin
                w              = pend.pop_front();
                host_req.valid = 1'b1;
                host_req.src   = tft_pkg::SRC_HOST;
                host_req.cmd   = w;
                credits--;
                words_sent++;
                if (w.delay.flag) begin
                    next_gap = next_gap + w.delay.count;
                end else begin
                    host_exp_word.push_back(w);
                    host_exp_gap.push_back(next_gap);
                    next_gap = 0;
                end
            end
            if (credits == 0) begin
                ran_out = 1'b1;
            end
        end
    end

    always @(negedge clk) begin : comparator
        logic [15:0] f;
        logic [31:0] iw;
        int          g;
        ref_t        r;
        tft_pkg::tft_rsp_t er;
        while (got_frames.size() > 0) begin
            f = got_frames.pop_front();
            g = got_gaps.pop_front();
            iw = (init_exp.size() > 0) ? init_exp[0] : 32'h0;
            if (init_exp.size() > 0 && (f == iw[15:0] || host_exp_word.size() == 0)) begin
                iw = init_exp.pop_front();
                r  = ref_frame(iw, ref_data);
                check_frame(f, r.frame, tft_pkg::SRC_INIT);
                ref_data = r.next_data;
            end else if (host_exp_word.size() > 0) begin
                r = ref_frame(host_exp_word.pop_front(), ref_data);
                check_frame(f, r.frame, tft_pkg::SRC_HOST);
                check_gap(g, host_exp_gap.pop_front());
                ref_data = r.next_data;
                if (r.is_read) begin
                    er.valid = 1'b1;
                    er.src   = tft_pkg::SRC_HOST;
                    er.data  = r.rd_byte;
                    rsp_exp.push_back(er);
                end
                if (init_exp.size() > 0) begin
                    host_between++;
                end
            end else begin
                errors++;
                $display("frame 0x%04h appeared on the SPI pins with nothing expected", f);
            end
        end
        if (host_rsp.valid === 1'b1) begin
            rsp_count++;
            if (rsp_exp.size() == 0) begin
                errors++;
                $display("a read response reached the host with no read pending");
            end else begin
                check_rsp(host_rsp, rsp_exp.pop_front());
            end
        end
    end

    task automatic apply_reset();
        @(negedge clk);
        nrst = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        if (chip_select !== 1'b1 || sclk !== 1'b1 || bit_data !== 1'b1 ||
            init_done !== 1'b0 || host_credit !== 1'b0 || host_rsp.valid !== 1'b0) begin
            errors++;
            $display("outputs are not at their reset values");
        end
        init_exp.push_back(32'h0000_8001);
        init_exp.push_back(32'h0000_0080);
        init_exp.push_back(32'h0000_0003);
        nrst = 1'b1;
    endtask

    task automatic wait_idle();
        do begin
            @(negedge clk);
        end while (pend.size() != 0 || host_exp_word.size() != 0 || init_exp.size() != 0 ||
                   chip_select !== 1'b1);
        repeat (4) @(negedge clk);
    endtask

    task automatic end_test(input int num, input string name);
        if (rsp_exp.size() != 0) begin
            errors++;
            $display("%0d read responses never arrived", rsp_exp.size());
            rsp_exp.delete();
        end
        if (errors == test_errors) begin
            tests_ok++;
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: %0d errors", num, name, errors - test_errors);
        end
    endtask

    initial begin : watchdog
        #(watchdog_cycles() * 100);
        $display("timeout, the tests did not finish within %0d cycles", watchdog_cycles());
        $display("TEST FAILED");
        $finish;
    end

    initial begin : main
        int          sent0;
        int          pulses0;
        int          rsp0;
        logic [7:0]  b;
        seed     = 53;
        nrst     = 1'b0;
        host_req = '0;
        miso     = 1'b0;
        ran_out  = 1'b0;

        apply_reset();
        test_errors = errors;
        wait (init_exp.size() == 0);
        // the power-up delay word sits between the last init frame and this one
        next_gap = INIT_DELAY;
        pend.push_back({24'h0, rand_byte()});
        wait_idle();
        if (init_done !== 1'b1) begin
            errors++;
            $display("init_done is not set after the power-up list");
        end
        end_test(1, "init sequence");

        test_errors = errors;
        repeat (NUM_WRITES) pend.push_back({24'h0, rand_byte()});
        wait_idle();
        end_test(2, "host write frames");

        test_errors = errors;
        rsp0 = rsp_count;
        repeat (NUM_READS) begin
            b = rand_byte();
            pend.push_back({24'h0, b});
            pend.push_back({16'h0, 8'h40, rand_byte()});
        end
        wait_idle();
        check_count("host_rsp count", rsp_count - rsp0, NUM_READS);
        end_test(3, "read-back");

        test_errors = errors;
        pend.push_back({24'h0, rand_byte()});
        pend.push_back({1'b1, 31'(DELAY_N)});
        pend.push_back({24'h0, rand_byte()});
        wait_idle();
        end_test(4, "delay command");

        test_errors = errors;
        repeat (BURSTS) begin
            ran_out = 1'b0;
            sent0   = words_sent;
            pulses0 = credit_pulses;
            pend.push_back({1'b1, 31'(LONG_DELAY)});
            repeat (BURST_FRAMES) pend.push_back({24'h0, rand_byte()});
            wait_idle();
            if (!ran_out) begin
                errors++;
                $display("the host never ran out of credits during a burst");
            end
            check_count("host_credit pulses", credit_pulses - pulses0, words_sent - sent0);
        end
        end_test(5, "credits and back-pressure");

        apply_reset();
        test_errors  = errors;
        host_between = 0;
        // bit 4 set keeps these frames apart from the power-up frames
        repeat (ARB_WORDS) pend.push_back({24'h0, rand_byte() | 8'h10});
        wait_idle();
        if (host_between == 0) begin
            errors++;
            $display("no host frame was sent between the power-up frames");
        end
        if (init_done !== 1'b1) begin
            errors++;
            $display("init_done is not set after the power-up list");
        end
        end_test(6, "arbitration");

        $display("summary: %0d tests ok, %0d tests with errors", tests_ok, tests_bad);
        if (errors == 0 && tests_bad == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+logic
logic/tft_pkg.sv
logic/tft_spi_engine.sv
logic/tft_cmd_queue.sv
logic/tft_init_seq.sv
logic/tft_spi_arbiter.sv
logic/tft_subsystem.sv
sim/tft_tb.sv
